//--- logic/softmax_defines.svh
`ifndef SOFTMAX_DEFINES_SVH
`define SOFTMAX_DEFINES_SVH

// block geometry.
`define SOFTMAX_N      8
`define SOFTMAX_IDX_W  3

// scores are Q4.4 signed.
`define DATA_W         8
`define FRAC_W         4

// max - score + log2 F, unsigned Q.4.
`define DIFF_W         10

// power of two result, Q1.16.
`define EXP_W          17

// running sum F, Q4.16.
`define SUM_W          20

// log2 F, Q3.4.
`define LOG_W          7

`endif

//--- logic/softmax_pkg.sv
`default_nettype none

`include "softmax_defines.svh"

package softmax_pkg;

    typedef logic signed [`DATA_W-1:0]  score_t;    // Q4.4.
    typedef logic [`SOFTMAX_IDX_W-1:0]  idx_t;
    typedef logic [`EXP_W-1:0]          exp_t;      // Q1.16.
    typedef logic [`SUM_W-1:0]          sum_t;      // Q4.16.
    typedef logic [`LOG_W-1:0]          log_t;      // Q3.4.

    typedef enum logic [2:0] {
        IDLE,
        FIND_MAX,
        EXP_SUM,
        LOG_SUM,
        NORMALIZE
    } stage_e;

    // broadcast from the controller to every stage unit.
    typedef struct packed {
        stage_e stage;
        idx_t   idx;
        logic   first;
        logic   last;
    } ctrl_t;

    typedef struct packed {
        logic   valid;
        logic   last;
        idx_t   idx;
        exp_t   prob;
    } prob_t;

endpackage

`default_nettype wire

//--- logic/element_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module element_store
    import softmax_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   in_valid,
    input  wire score_t in_data,
    input  wire logic   busy,
    input  wire idx_t   rd_idx,
    output logic        block_full,
    output score_t      rd_data
);

    score_t mem [`SOFTMAX_N];
    idx_t   wr_ptr;
    logic   wr_en;

    assign wr_en = in_valid && !busy;   // dropped while a block runs.

    ////////////////////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;    // wraps at N.
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // high while the N-th score is being written.
    assign block_full = wr_en && (wr_ptr == idx_t'(`SOFTMAX_N - 1));

    ////////////////////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////////////////////

    assign rd_data = mem[rd_idx];

endmodule

`default_nettype wire

//--- logic/softmax_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module softmax_controller
    import softmax_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic block_full,
    output logic      busy,
    output ctrl_t     ctrl
);

    stage_e state;
    stage_e next_state;
    idx_t   cnt;
    idx_t   cnt_limit;
    logic   cnt_last;

    ////////////////////////////////////////////////////////////////////////////
    // stage length and successor
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            FIND_MAX: begin
                cnt_limit  = idx_t'(`SOFTMAX_N - 1);
                next_state = EXP_SUM;
            end
            EXP_SUM: begin
                cnt_limit  = idx_t'(`SOFTMAX_N - 1);
                next_state = LOG_SUM;
            end
            LOG_SUM: begin
                cnt_limit  = idx_t'(1);     // absorb, then take the log.
                next_state = NORMALIZE;
            end
            NORMALIZE: begin
                cnt_limit  = idx_t'(`SOFTMAX_N - 1);
                next_state = IDLE;
            end
            default: begin
                cnt_limit  = '0;
                next_state = FIND_MAX;
            end
        endcase
    end

    assign cnt_last = (cnt == cnt_limit);

    ////////////////////////////////////////////////////////////////////////////
    // state and cycle counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else if (state == IDLE) begin
            cnt <= '0;
            if (block_full) begin
                state <= FIND_MAX;
            end
        end else if (cnt_last) begin
            state <= next_state;
            cnt   <= '0;            // restart for the next stage.
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign busy = (state != IDLE);

    always_comb begin
        ctrl.stage = state;
        ctrl.idx   = cnt;
        ctrl.first = busy && (cnt == '0);
        ctrl.last  = busy && cnt_last;
    end

endmodule

`default_nettype wire

//--- logic/max_search.sv
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module max_search
    import softmax_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire ctrl_t  ctrl,
    input  wire score_t rd_data,
    output score_t      xmax
);

    logic scan;
    logic take;

    assign scan = (ctrl.stage == FIND_MAX);

    // signed compare, score_t is signed.
    assign take = ctrl.first || (rd_data > xmax);

    always_ff @(posedge clk) begin
        if (rst) begin
            xmax <= '0;
        end else if (scan && take) begin
            xmax <= rd_data;        // held until the next block.
        end
    end

endmodule

`default_nettype wire

//--- logic/exp2_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module exp2_unit
    import softmax_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire ctrl_t  ctrl,
    input  wire score_t rd_data,
    input  wire score_t xmax,
    input  wire log_t   log_f,
    output exp_t        exp_res,
    output stage_e      exp_stage,
    output prob_t       result
);

    localparam int K_W        = `DIFF_W - `FRAC_W;
    localparam int MANT_SHIFT = `EXP_W - 2 - `FRAC_W;  // f * 2048.

    logic signed [`DIFF_W-1:0] xmax_ext;
    logic signed [`DIFF_W-1:0] data_ext;
    logic [`DIFF_W-1:0]        d;
    logic [K_W-1:0]            k;
    logic [`FRAC_W-1:0]        f;
    exp_t                      mant;
    exp_t                      exp_val;
    logic                      res_valid;
    logic                      res_last;
    idx_t                      res_idx;

    // 2^-d with d = k + f/16, approximated as (1 - f/32) >> k.
    always_comb begin
        xmax_ext = xmax;
        data_ext = rd_data;
        d = xmax_ext - data_ext;
        if (ctrl.stage == NORMALIZE) begin
            d = d + {{(`DIFF_W - `LOG_W){1'b0}}, log_f};
        end
        k       = d[`DIFF_W-1:`FRAC_W];
        f       = d[`FRAC_W-1:0];
        mant    = {1'b1, {(`EXP_W - 1){1'b0}}} - (exp_t'(f) << MANT_SHIFT);
        exp_val = (k >= K_W'(`EXP_W)) ? '0 : (mant >> k);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exp_stage <= IDLE;
            res_valid <= 1'b0;
            res_last  <= 1'b0;
        end else begin
            exp_stage <= ctrl.stage;    // tag follows the operand.
            res_valid <= (ctrl.stage == NORMALIZE);
            res_last  <= (ctrl.stage == NORMALIZE) && ctrl.last;
        end
    end

    always_ff @(posedge clk) begin
        exp_res <= exp_val;
        if (ctrl.stage == NORMALIZE) begin
            res_idx <= ctrl.idx;
        end
    end

    assign result = '{valid: res_valid, last: res_last, idx: res_idx, prob: exp_res};

endmodule

`default_nettype wire

//--- logic/sum_log_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module sum_log_unit
    import softmax_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire ctrl_t  ctrl,
    input  wire exp_t   exp_res,
    input  wire stage_e exp_stage,
    output log_t        log_f
);

    localparam int ONE_POS = `EXP_W - 1;        // weight of 1.0 in the sum.
    localparam int INT_W   = `LOG_W - `FRAC_W;

    sum_t                sum;
    logic [INT_W-1:0]    log_int;
    logic [`FRAC_W-1:0]  log_frac;

    ////////////////////////////////////////////////////////////////////////////
    // accumulate F
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            sum <= '0;
        end else if ((ctrl.stage == EXP_SUM) && ctrl.first) begin
            sum <= '0;
        end else if (exp_stage == EXP_SUM) begin
            sum <= sum + {{(`SUM_W - `EXP_W){1'b0}}, exp_res};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // log2 F from the leading one
    ////////////////////////////////////////////////////////////////////////////

    // F is at least 1.0, so the leading one sits at ONE_POS or above.
    always_comb begin
        log_int  = '0;
        log_frac = sum[ONE_POS-1 -: `FRAC_W];
        for (int p = ONE_POS; p < `SUM_W; p++) begin
            if (sum[p]) begin
                log_int  = INT_W'(p - ONE_POS);
                log_frac = sum[p-1 -: `FRAC_W];     // mantissa bits below.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            log_f <= '0;
        end else if ((ctrl.stage == LOG_SUM) && ctrl.last) begin
            log_f <= {log_int, log_frac};
        end
    end

endmodule

`default_nettype wire

//--- logic/softmax_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module softmax_top
    import softmax_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   in_valid,
    input  wire score_t in_data,
    output logic        busy,
    output prob_t       result
);

    logic   block_full;
    score_t rd_data;
    ctrl_t  ctrl;
    score_t xmax;
    log_t   log_f;
    exp_t   exp_res;
    stage_e exp_stage;

    element_store store_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .busy       (busy),
        .rd_idx     (ctrl.idx),
        .block_full (block_full),
        .rd_data    (rd_data)
    );

    softmax_controller ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .block_full (block_full),
        .busy       (busy),
        .ctrl       (ctrl)
    );

    max_search max_i (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .rd_data    (rd_data),
        .xmax       (xmax)
    );

    // shared by EXP_SUM and NORMALIZE.
    exp2_unit exp_i (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .rd_data    (rd_data),
        .xmax       (xmax),
        .log_f      (log_f),
        .exp_res    (exp_res),
        .exp_stage  (exp_stage),
        .result     (result)
    );

    sum_log_unit sum_i (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .exp_res    (exp_res),
        .exp_stage  (exp_stage),
        .log_f      (log_f)
    );

endmodule

`default_nettype wire

//--- testbench/softmax_checks.svh
`ifndef SOFTMAX_CHECKS_SVH
`define SOFTMAX_CHECKS_SVH

int error_count   = 0;
int timeout_count = 0;

task automatic check_prob(input string name, input exp_t expected, input exp_t actual);
    if (actual !== expected) begin
        error_count++;
        $display("ERROR at time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
endtask

task automatic check_idx(input string name, input idx_t expected, input idx_t actual);
    if (actual !== expected) begin
        error_count++;
        $display("ERROR at time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        error_count++;
        $display("ERROR at time %0t: %s expected %b, got %b", $time, name, expected, actual);
    end
endtask

////////////////////////////////////////////////////////////////////////////
// bounded waits, sampled on the falling edge
////////////////////////////////////////////////////////////////////////////

task automatic wait_result(input int limit, output int cycles, output logic seen);
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < limit) begin
        @(negedge clk);
        cycles++;
        seen = (result.valid === 1'b1);
    end
    if (!seen) begin
        timeout_count++;
        $display("timeout: no valid result within %0d cycles at time %0t", limit, $time);
    end
endtask

task automatic wait_idle(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (busy !== 1'b0 && n < limit) begin
        @(negedge clk);
        n++;
    end
    if (busy !== 1'b0) begin
        timeout_count++;
        $display("timeout: engine still busy after %0d cycles at time %0t", limit, $time);
    end
endtask

`endif

//--- testbench/softmax_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "softmax_defines.svh"

module softmax_tb
    import softmax_pkg::*;
();

    localparam int N           = `SOFTMAX_N;
    localparam int FIRST_CYCLE = 2 * N + 4;     // first result cycle after the load.

    logic   clk;
    logic   rst;
    logic   in_valid;
    score_t in_data;
    logic   busy;
    prob_t  result;

    int     seed = 32'h5264;
    score_t block [N];
    exp_t   expected [N];

    softmax_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_data  (in_data),
        .busy     (busy),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    `include "softmax_checks.svh"

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // 2^-(d/16) as a linear segment per octave in Q1.16.
    function automatic exp_t pow2_neg(input int d);
        int k;
        int f;
        k = d / 16;
        f = d % 16;
        if (k >= 17) begin
            return '0;
        end
        return exp_t'((65536 - f * 2048) >> k);
    endfunction

    // leading one gives the integer and the next four bits the fraction.
    function automatic int log2_fixed(input int sum);
        int p;
        p = 16;
        for (int b = 16; b < 20; b++) begin
            if (sum[b]) begin
                p = b;
            end
        end
        return (p - 16) * 16 + ((sum >> (p - 4)) & 15);
    endfunction

    task automatic compute_expected();
        int max_v;
        int sum;
        int log_v;
        max_v = block[0];
        for (int i = 1; i < N; i++) begin
            if (int'(block[i]) > max_v) begin
                max_v = block[i];
            end
        end
        sum = 0;
        for (int i = 0; i < N; i++) begin
            sum += int'(pow2_neg(max_v - block[i]));
        end
        log_v = log2_fixed(sum);
        for (int i = 0; i < N; i++) begin
            expected[i] = pow2_neg(max_v - block[i] + log_v);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus and response
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_block();
        for (int i = 0; i < N; i++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_data  <= block[i];
        end
        @(posedge clk);                 // last score written here.
        in_valid <= 1'b0;
        in_data  <= '0;
    endtask

    task automatic drive_junk(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_data  <= score_t'($random(seed));
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic check_results();
        int   cycles;
        logic seen;
        @(negedge clk);
        check_flag("busy", 1'b1, busy);
        wait_result(4 * N, cycles, seen);
        if (seen) begin
            if (cycles + 1 != FIRST_CYCLE) begin
                error_count++;
                $display("ERROR at time %0t: result latency expected %0d, got %0d",
                         $time, FIRST_CYCLE, cycles + 1);
            end
            for (int i = 0; i < N; i++) begin
                if (i > 0) begin
                    @(negedge clk);
                end
                check_flag("result.valid", 1'b1, result.valid);
                check_idx("result.idx", idx_t'(i), result.idx);
                check_flag("result.last", logic'(i == N - 1), result.last);
                check_prob($sformatf("result.prob[%0d]", i), expected[i], result.prob);
                check_flag("busy", logic'(i < N - 1), busy);    // falls after NORMALIZE.
            end
            @(negedge clk);
            check_flag("result.valid", 1'b0, result.valid);
        end
        wait_idle(4 * N);
    endtask

    task automatic run_block();
        compute_expected();
        wait_idle(4 * N);
        load_block();
        check_results();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_state_test();
        @(negedge clk);
        check_flag("busy", 1'b0, busy);
        check_flag("result.valid", 1'b0, result.valid);
        for (int i = 0; i < N; i++) begin
            block[i] = score_t'($random(seed));
        end
        run_block();
    endtask

    task automatic equal_scores_test();
        for (int i = 0; i < N; i++) begin
            block[i]    = 8'sh18;
            expected[i] = 17'd8192;     // F = 8 and log2 F = 3.0.
        end
        wait_idle(4 * N);
        load_block();
        check_results();
    endtask

    task automatic dominant_score_test();
        for (int i = 0; i < N; i++) begin
            block[i] = -8'sd32;
        end
        block[5] = 8'sd100;
        run_block();
    endtask

    task automatic random_blocks_test();
        for (int b = 0; b < 5; b++) begin
            for (int i = 0; i < N; i++) begin
                if (b == 3) begin
                    block[i] = score_t'(-1 - ($random(seed) & 63));   // all negative.
                end else begin
                    block[i] = score_t'($random(seed));
                end
            end
            run_block();
        end
    endtask

    task automatic ignored_load_test();
        for (int i = 0; i < N; i++) begin
            block[i] = score_t'($random(seed));
        end
        compute_expected();
        wait_idle(4 * N);
        load_block();
        fork
            drive_junk(12);
            check_results();
        join
        for (int i = 0; i < N; i++) begin
            block[i] = score_t'($random(seed));
        end
        run_block();
    endtask

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_data  = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        reset_state_test();
        equal_scores_test();
        dominant_score_test();
        random_blocks_test();
        ignored_load_test();

        $display("mismatches: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
+incdir+testbench
logic/softmax_pkg.sv
logic/element_store.sv
logic/softmax_controller.sv
logic/max_search.sv
logic/exp2_unit.sv
logic/sum_log_unit.sv
logic/softmax_top.sv
testbench/softmax_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the softmax testbench with Verilator, run it, and judge the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    -f sources.f \
    --top-module softmax_tb \
    -o softmax_sim

./obj_dir/softmax_sim > sim.log 2>&1
cat sim.log

if grep -q "All checks passed" sim.log; then
    echo "simulation PASSED"
    exit 0
else
    echo "simulation FAILED"
    exit 1
fi
